/* Bender.yml */
package:
  name: qsim

sources:
  - include_dirs:
      - include
    files:
      - hw/qsim_pkg.sv
      - hw/qsim_job_config.sv
      - hw/qsim_seq.sv
      - hw/qsim_addr_gen.sv
      - hw/qsim_cmac.sv
      - hw/qsim_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/qsim_chk.sv
      - test/qsim_monitor.sv
      - test/qsim_tb.sv

/* hw/qsim_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qsim_params.svh"

module qsim_addr_gen
  import qsim_pkg::*;
(
  input  wire                     clk,
  input  wire                     reset_n,
  input  wire                     walk_start,
  input  wire [`QSIM_QUBIT_W-1:0] num_qubits,
  input  wire addr_t              gate_offset,
  input  wire                     src_is_scratch,
  input  wire                     header_read,
  output addr_t                   gate_addr,
  output addr_t                   state_read_addr,
  output logic                    op_valid,
  output logic                    row_first,
  output logic                    op_from_scratch,
  output addr_t                   write_addr,
  output logic                    input_we,
  output logic                    scratch_we,
  output logic                    output_we,
  output addr_t                   output_addr,
  output logic                    walk_done
);

  localparam int RD_LAT = `QSIM_READ_LATENCY;
  localparam int WR_LAT = `QSIM_READ_LATENCY + `QSIM_MAC_LATENCY;
  localparam int ROW_W  = `QSIM_MAX_QUBITS;
  localparam int CNT_W  = `QSIM_COUNT_W;

  logic [CNT_W-1:0] elem;
  logic [CNT_W-1:0] elem_last;
  logic             walking;
  logic [ROW_W-1:0] col_mask;
  logic [ROW_W-1:0] row;
  logic [ROW_W-1:0] col;
  logic             is_row_first;
  logic             is_row_last;
  logic             is_walk_last;

  // N*N elements, column is the low Q bits of the counter
  assign elem_last = (CNT_W'(1) << (2 * num_qubits)) - 1'b1;
  assign col_mask  = ROW_W'((1 << num_qubits) - 1);
  assign row       = ROW_W'(elem >> num_qubits);
  assign col       = ROW_W'(elem) & col_mask;

  assign is_row_first = walking && (col == '0);
  assign is_row_last  = walking && (col == col_mask);
  assign is_walk_last = walking && (elem == elem_last);

  // --------------------------------------------------
  // element walk
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      walking <= 1'b0;
      elem    <= '0;
    end else if (walk_start) begin
      walking <= 1'b1;
      elem    <= '0;
    end else if (walking) begin
      if (elem == elem_last) begin
        walking <= 1'b0;
      end else begin
        elem <= elem + 1'b1;
      end
    end
  end

  assign gate_addr = gate_offset + addr_t'(elem);

  // input memory keeps the header at 0, so its vector starts at 1
  always_comb begin
    if (header_read) begin
      state_read_addr = '0;
    end else if (src_is_scratch) begin
      state_read_addr = addr_t'(col);
    end else begin
      state_read_addr = addr_t'(col) + 1'b1;
    end
  end

  // --------------------------------------------------
  // tags aligned with read data
  // --------------------------------------------------
  logic [RD_LAT-1:0] valid_pipe;
  logic [RD_LAT-1:0] first_pipe;
  logic [RD_LAT-1:0] scr_pipe;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_pipe <= '0;
      first_pipe <= '0;
      scr_pipe   <= '0;
    end else begin
      valid_pipe[0] <= walking;
      first_pipe[0] <= is_row_first;
      scr_pipe[0]   <= src_is_scratch;
      for (int i = 1; i < RD_LAT; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
        first_pipe[i] <= first_pipe[i-1];
        scr_pipe[i]   <= scr_pipe[i-1];
      end
    end
  end

  assign op_valid        = valid_pipe[RD_LAT-1];
  assign row_first       = first_pipe[RD_LAT-1];
  assign op_from_scratch = scr_pipe[RD_LAT-1];

  // --------------------------------------------------
  // row tags through read and mac latency
  // --------------------------------------------------
  logic [WR_LAT-1:0] wr_pipe;
  logic [WR_LAT-1:0] end_pipe;
  logic [WR_LAT-1:0] dst_in_pipe;
  logic [ROW_W-1:0]  row_pipe [WR_LAT];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_pipe     <= '0;
      end_pipe    <= '0;
      dst_in_pipe <= '0;
      walk_done   <= 1'b0;
    end else begin
      wr_pipe[0]     <= is_row_last;
      end_pipe[0]    <= is_walk_last;
      dst_in_pipe[0] <= src_is_scratch;
      for (int i = 1; i < WR_LAT; i++) begin
        wr_pipe[i]     <= wr_pipe[i-1];
        end_pipe[i]    <= end_pipe[i-1];
        dst_in_pipe[i] <= dst_in_pipe[i-1];
      end
      walk_done <= end_pipe[WR_LAT-1];
    end
  end

  always_ff @(posedge clk) begin
    row_pipe[0] <= row;
    for (int i = 1; i < WR_LAT; i++) begin
      row_pipe[i] <= row_pipe[i-1];
    end
  end

  // odd gates read the scratchpad and write back into the input memory
  assign output_we   = wr_pipe[WR_LAT-1];
  assign input_we    = wr_pipe[WR_LAT-1] && dst_in_pipe[WR_LAT-1];
  assign scratch_we  = wr_pipe[WR_LAT-1] && !dst_in_pipe[WR_LAT-1];
  assign output_addr = addr_t'(row_pipe[WR_LAT-1]);
  assign write_addr  = dst_in_pipe[WR_LAT-1] ? output_addr + 1'b1 : output_addr;

endmodule

`default_nettype wire

/* hw/qsim_cmac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qsim_params.svh"

module qsim_cmac
  import qsim_pkg::*;
(
  input  wire        clk,
  input  wire        reset_n,
  input  wire        op_valid,
  input  wire        row_first,
  input  wire        op_from_scratch,
  input  wire word_t input_data,
  input  wire word_t scratch_data,
  input  wire word_t gate_data,
  output word_t      acc
);

  localparam int FRAC = `QSIM_FRAC_BITS;
  localparam int PW   = `QSIM_PART_W;

  // full product, then drop the fraction and wrap to one part
  function automatic part_t scaled_mul(input part_t a, input part_t b);
    logic signed [2*PW-1:0] full;
    full = a * b;
    return part_t'(full >>> FRAC);
  endfunction

  word_t state_op;
  part_t v_re;
  part_t v_im;
  part_t g_re;
  part_t g_im;

  assign state_op = op_from_scratch ? scratch_data : input_data;
  assign v_re     = state_op[`QSIM_DATA_W-1 -: PW];
  assign v_im     = state_op[PW-1:0];
  assign g_re     = gate_data[`QSIM_DATA_W-1 -: PW];
  assign g_im     = gate_data[PW-1:0];

  // --------------------------------------------------
  // stage 1, part products
  // --------------------------------------------------
  logic  s1_valid;
  logic  s1_first;
  part_t p_rr;
  part_t p_ii;
  part_t p_ri;
  part_t p_ir;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      s1_valid <= 1'b0;
      s1_first <= 1'b0;
    end else begin
      s1_valid <= op_valid;
      s1_first <= row_first;
    end
  end

  always_ff @(posedge clk) begin
    p_rr <= scaled_mul(g_re, v_re);
    p_ii <= scaled_mul(g_im, v_im);
    p_ri <= scaled_mul(g_re, v_im);
    p_ir <= scaled_mul(g_im, v_re);
  end

  // --------------------------------------------------
  // stage 2, complex product
  // --------------------------------------------------
  logic  s2_valid;
  logic  s2_first;
  part_t prod_re;
  part_t prod_im;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      s2_valid <= 1'b0;
      s2_first <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s2_first <= s1_first;
    end
  end

  always_ff @(posedge clk) begin
    prod_re <= p_rr - p_ii;
    prod_im <= p_ri + p_ir;
  end

  // stage 3, accumulate; first column of a row loads instead
  part_t acc_re;
  part_t acc_im;

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      if (s2_first) begin
        acc_re <= prod_re;
        acc_im <= prod_im;
      end else begin
        acc_re <= acc_re + prod_re;
        acc_im <= acc_im + prod_im;
      end
    end
  end

  assign acc = {acc_re, acc_im};

endmodule

`default_nettype wire

/* hw/qsim_job_config.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qsim_params.svh"

module qsim_job_config
  import qsim_pkg::*;
(
  input  wire                      clk,
  input  wire                      reset_n,
  input  wire                      capture_header,
  input  wire                      job_clear,
  input  wire                      gate_step,
  input  wire word_t               header_word,
  output logic [`QSIM_QUBIT_W-1:0] num_qubits,
  output logic                     gates_left_is_one,
  output addr_t                    gate_offset,
  output logic                     src_is_scratch
);

  logic [`QSIM_COUNT_W-1:0] gates_left;
  addr_t                    gate_span;

  // one gate matrix is N*N words
  assign gate_span = addr_t'(1) << (2 * num_qubits);

  // --------------------------------------------------
  // header fields and gate countdown
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      num_qubits <= '0;
      gates_left <= '0;
    end else if (capture_header) begin
      num_qubits <= header_word[`QSIM_DATA_W/2 +: `QSIM_QUBIT_W];
      gates_left <= header_word[`QSIM_COUNT_W-1:0];
    end else if (gate_step) begin
      gates_left <= gates_left - 1'b1;
    end
  end

  assign gates_left_is_one = (gates_left == `QSIM_COUNT_W'(1));

  // gate base address and ping-pong select
  always_ff @(posedge clk) begin
    if (!reset_n || job_clear) begin
      gate_offset    <= '0;
      src_is_scratch <= 1'b0;
    end else if (gate_step) begin
      gate_offset    <= gate_offset + gate_span;
      src_is_scratch <= !src_is_scratch;
    end
  end

endmodule

`default_nettype wire

/* hw/qsim_pkg.sv */
`default_nettype none

`include "qsim_params.svh"

package qsim_pkg;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOAD_HEADER,
    SETUP,
    STREAM,
    DRAIN,
    NEXT_GATE
  } seq_state_e;

  typedef logic signed [`QSIM_PART_W-1:0] part_t;

  // real part in the upper half, imaginary in the lower half
  typedef logic [`QSIM_DATA_W-1:0] word_t;

  typedef logic [`QSIM_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

/* hw/qsim_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module qsim_seq
  import qsim_pkg::*;
(
  input  wire  clk,
  input  wire  reset_n,
  input  wire  dut_valid,
  input  wire  gates_left_is_one,
  input  wire  walk_done,
  output logic dut_ready,
  output logic capture_header,
  output logic job_clear,
  output logic gate_step,
  output logic walk_start,
  output logic header_read
);

  seq_state_e state;
  seq_state_e state_next;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // next state and control strobes
  // --------------------------------------------------
  always_comb begin
    state_next     = state;
    dut_ready      = 1'b0;
    capture_header = 1'b0;
    job_clear      = 1'b0;
    gate_step      = 1'b0;
    walk_start     = 1'b0;
    header_read    = 1'b0;
    case (state)
      IDLE: begin
        dut_ready = 1'b1;
        if (dut_valid) begin
          state_next = LOAD_HEADER;
        end
      end
      LOAD_HEADER: begin
        // address 0 goes out now, word comes back next cycle
        header_read = 1'b1;
        job_clear   = 1'b1;
        state_next  = SETUP;
      end
      SETUP: begin
        capture_header = 1'b1;
        state_next     = STREAM;
      end
      STREAM: begin
        walk_start = 1'b1;
        state_next = DRAIN;
      end
      DRAIN: begin
        // wait for the last row write of this gate
        if (walk_done) begin
          state_next = NEXT_GATE;
        end
      end
      NEXT_GATE: begin
        if (gates_left_is_one) begin
          state_next = IDLE;
        end else begin
          gate_step  = 1'b1;
          state_next = STREAM;
        end
      end
      default: state_next = IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* hw/qsim_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qsim_params.svh"

module qsim_top
  import qsim_pkg::*;
(
  input  wire        clk,
  input  wire        reset_n,
  input  wire        dut_valid,
  output wire        dut_ready,

  // input state memory, header at address 0
  output wire        q_state_input_sram_write_enable,
  output wire addr_t q_state_input_sram_write_address,
  output wire word_t q_state_input_sram_write_data,
  output wire addr_t q_state_input_sram_read_address,
  input  wire word_t q_state_input_sram_read_data,

  // output state memory, write only
  output wire        q_state_output_sram_write_enable,
  output wire addr_t q_state_output_sram_write_address,
  output wire word_t q_state_output_sram_write_data,
  input  wire word_t q_state_output_sram_read_data,

  output wire        scratchpad_sram_write_enable,
  output wire addr_t scratchpad_sram_write_address,
  output wire word_t scratchpad_sram_write_data,
  output wire addr_t scratchpad_sram_read_address,
  input  wire word_t scratchpad_sram_read_data,

  output wire addr_t q_gates_sram_read_address,
  input  wire word_t q_gates_sram_read_data
);

  logic                     capture_header;
  logic                     job_clear;
  logic                     gate_step;
  logic                     walk_start;
  logic                     walk_done;
  logic                     header_read;
  logic [`QSIM_QUBIT_W-1:0] num_qubits;
  logic                     gates_left_is_one;
  addr_t                    gate_offset;
  logic                     src_is_scratch;
  addr_t                    state_read_addr;
  addr_t                    write_addr;
  addr_t                    output_addr;
  logic                     op_valid;
  logic                     row_first;
  logic                     op_from_scratch;
  word_t                    acc;

  qsim_seq qsim_seq_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .dut_valid        (dut_valid),
    .gates_left_is_one(gates_left_is_one),
    .walk_done        (walk_done),
    .dut_ready        (dut_ready),
    .capture_header   (capture_header),
    .job_clear        (job_clear),
    .gate_step        (gate_step),
    .walk_start       (walk_start),
    .header_read      (header_read)
  );

  qsim_job_config qsim_job_config_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .capture_header   (capture_header),
    .job_clear        (job_clear),
    .gate_step        (gate_step),
    .header_word      (q_state_input_sram_read_data),
    .num_qubits       (num_qubits),
    .gates_left_is_one(gates_left_is_one),
    .gate_offset      (gate_offset),
    .src_is_scratch   (src_is_scratch)
  );

  qsim_addr_gen qsim_addr_gen_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .walk_start     (walk_start),
    .num_qubits     (num_qubits),
    .gate_offset    (gate_offset),
    .src_is_scratch (src_is_scratch),
    .header_read    (header_read),
    .gate_addr      (q_gates_sram_read_address),
    .state_read_addr(state_read_addr),
    .op_valid       (op_valid),
    .row_first      (row_first),
    .op_from_scratch(op_from_scratch),
    .write_addr     (write_addr),
    .input_we       (q_state_input_sram_write_enable),
    .scratch_we     (scratchpad_sram_write_enable),
    .output_we      (q_state_output_sram_write_enable),
    .output_addr    (output_addr),
    .walk_done      (walk_done)
  );

  qsim_cmac qsim_cmac_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .op_valid       (op_valid),
    .row_first      (row_first),
    .op_from_scratch(op_from_scratch),
    .input_data     (q_state_input_sram_read_data),
    .scratch_data   (scratchpad_sram_read_data),
    .gate_data      (q_gates_sram_read_data),
    .acc            (acc)
  );

  // both state memories share one read address, the cmac picks the source
  assign q_state_input_sram_read_address   = state_read_addr;
  assign scratchpad_sram_read_address      = state_read_addr;

  assign q_state_input_sram_write_address  = write_addr;
  assign scratchpad_sram_write_address     = write_addr;
  assign q_state_output_sram_write_address = output_addr;

  // every row sum goes to all three write ports, enables decide
  assign q_state_input_sram_write_data     = acc;
  assign scratchpad_sram_write_data        = acc;
  assign q_state_output_sram_write_data    = acc;

endmodule

`default_nettype wire

/* include/qsim_params.svh */
`ifndef QSIM_PARAMS_SVH
`define QSIM_PARAMS_SVH

// qubit range and header field
`define QSIM_MAX_QUBITS    4
`define QSIM_QUBIT_W       3

// amplitude format, signed fixed point per part
`define QSIM_DATA_W        32
`define QSIM_PART_W        16
`define QSIM_FRAC_BITS     13

// memory addressing and counters
`define QSIM_ADDR_W        16
`define QSIM_COUNT_W       16

// operand arrival to accumulator, and sram read
`define QSIM_MAC_LATENCY   3
`define QSIM_READ_LATENCY  1

`endif

/* src.f */
+incdir+include
hw/qsim_pkg.sv
hw/qsim_job_config.sv
hw/qsim_seq.sv
hw/qsim_addr_gen.sv
hw/qsim_cmac.sv
hw/qsim_top.sv
test/qsim_chk.sv
test/qsim_monitor.sv
test/qsim_tb.sv

/* test/qsim_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qsim_params.svh"

module qsim_chk
  import qsim_pkg::*;
(
  input wire clk,
  input wire reset_n,
  input wire dut_ready,
  input wire input_we,
  input wire scratch_we,
  input wire output_we
);

  int assert_fails;

  initial begin
    assert_fails = 0;
  end

  // the engine only writes while a job is running
  assert property (@(posedge clk) disable iff (!reset_n)
    (input_we || scratch_we || output_we) |-> !dut_ready)
    else begin
      assert_fails++;
      $error("write enable high while dut_ready is high");
    end

  // ping-pong sends each row to one state memory
  assert property (@(posedge clk) disable iff (!reset_n) !(input_we && scratch_we))
    else begin
      assert_fails++;
      $error("input and scratchpad write enables high together");
    end

  assert property (@(posedge clk) $rose(reset_n) |-> !(input_we || scratch_we || output_we))
    else begin
      assert_fails++;
      $error("write enable high in the first cycle after reset");
    end

endmodule

`default_nettype wire

/* test/qsim_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qsim_params.svh"

module qsim_monitor
  import qsim_pkg::*;
#(
  parameter int ROWS = 1 << `QSIM_MAX_QUBITS
) (
  input  wire                         clk,
  input  wire                         dut_valid,
  input  wire                         dut_ready,
  input  wire                         out_we,
  input  wire addr_t                  out_addr,
  input  wire word_t                  out_data,
  input  wire                         in_we,
  input  wire addr_t                  in_addr,
  input  wire word_t                  in_data,
  input  wire                         scr_we,
  input  wire addr_t                  scr_addr,
  input  wire word_t                  scr_data,
  input  wire [`QSIM_MAX_QUBITS:0]    num_rows,
  input  wire                         input_expected,
  input  wire [ROWS*`QSIM_DATA_W-1:0] exp_out,
  input  wire [ROWS*`QSIM_DATA_W-1:0] exp_in,
  input  wire [ROWS*`QSIM_DATA_W-1:0] exp_scr,
  output int                          mismatch_count,
  output int                          other_count,
  output int                          jobs_checked
);

  localparam int W = `QSIM_DATA_W;

  logic [ROWS*W-1:0] got_out;
  logic [ROWS*W-1:0] got_in;
  logic [ROWS*W-1:0] got_scr;
  logic [ROWS-1:0]   seen_out;
  logic [ROWS-1:0]   seen_in;
  logic [ROWS-1:0]   seen_scr;
  logic [ROWS*W-1:0] want_out;
  logic [ROWS*W-1:0] want_in;
  logic [ROWS*W-1:0] want_scr;
  int                rows;
  bit                want_input;
  bit                job_active;

  initial begin
    mismatch_count = 0;
    other_count    = 0;
    jobs_checked   = 0;
    job_active     = 1'b0;
  end

  task automatic check_memory(input string name, input logic [ROWS*W-1:0] got,
                              input logic [ROWS-1:0] seen, input logic [ROWS*W-1:0] want,
                              input int base);
    word_t g;
    word_t e;
    for (int r = 0; r < rows; r++) begin
      g = got[r*W +: W];
      e = want[r*W +: W];
      if (!seen[r]) begin
        other_count++;
        $display("%s at address %0d was never written", name, r + base);
      end else if (g !== e) begin
        mismatch_count++;
        $display("Mismatch %s at address %0d: got %h, expected %h", name, r + base, g, e);
      end
    end
  endtask

  // --------------------------------------------------
  // record writes, compare when dut_ready comes back
  // --------------------------------------------------
  always @(posedge clk) begin
    if (out_we) begin
      if (!job_active || out_addr >= rows) begin
        other_count++;
        $display("unexpected output memory write at address %0d", out_addr);
      end else begin
        got_out[out_addr*W +: W] = out_data;
        seen_out[out_addr]       = 1'b1;
      end
    end
    if (in_we) begin
      if (!job_active || !want_input || in_addr == 0 || in_addr > rows) begin
        other_count++;
        $display("unexpected input memory write at address %0d", in_addr);
      end else begin
        got_in[(in_addr-1)*W +: W] = in_data;
        seen_in[in_addr-1]         = 1'b1;
      end
    end
    if (scr_we) begin
      if (!job_active || scr_addr >= rows) begin
        other_count++;
        $display("unexpected scratchpad write at address %0d", scr_addr);
      end else begin
        got_scr[scr_addr*W +: W] = scr_data;
        seen_scr[scr_addr]       = 1'b1;
      end
    end
    if (job_active && dut_ready) begin
      check_memory("q_state_output_sram_write_data", got_out, seen_out, want_out, 0);
      check_memory("scratchpad_sram_write_data", got_scr, seen_scr, want_scr, 0);
      if (want_input) begin
        check_memory("q_state_input_sram_write_data", got_in, seen_in, want_in, 1);
      end
      jobs_checked++;
      job_active = 1'b0;
    end
    // a job is accepted here, so its expected rows are frozen now
    if (dut_valid && dut_ready) begin
      got_out    = '0;
      got_in     = '0;
      got_scr    = '0;
      seen_out   = '0;
      seen_in    = '0;
      seen_scr   = '0;
      want_out   = exp_out;
      want_in    = exp_in;
      want_scr   = exp_scr;
      rows       = int'(num_rows);
      want_input = input_expected;
      job_active = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* test/qsim_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qsim_params.svh"

module qsim_tb
  import qsim_pkg::*;
();

  localparam int ROWS    = 1 << `QSIM_MAX_QUBITS;
  localparam int W       = `QSIM_DATA_W;
  localparam int PW      = `QSIM_PART_W;
  localparam int TIMEOUT = 4000;

  logic clk;
  logic reset_n;
  logic dut_valid;
  logic dut_ready;
  logic in_we;
  addr_t in_waddr;
  word_t in_wdata;
  addr_t in_raddr;
  word_t in_rdata;
  logic out_we;
  addr_t out_waddr;
  word_t out_wdata;
  word_t out_rdata;
  logic scr_we;
  addr_t scr_waddr;
  word_t scr_wdata;
  addr_t scr_raddr;
  word_t scr_rdata;
  addr_t gate_raddr;
  word_t gate_rdata;

  word_t gate_mem [1024];
  word_t in_mem [ROWS+1];
  word_t scr_mem [ROWS];
  word_t state_init [ROWS+1];
  logic  load_input;

  logic [ROWS*W-1:0]        exp_out;
  logic [ROWS*W-1:0]        exp_in;
  logic [ROWS*W-1:0]        exp_scr;
  logic [`QSIM_MAX_QUBITS:0] num_rows;
  logic                     input_expected;
  logic [31:0]              lfsr;
  int mismatch_count;
  int other_count;
  int jobs_checked;
  int tb_errors;
  int timeouts;
  int jobs_run;
  int assert_fails;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  qsim_top qsim_top_i (
    .clk                              (clk),
    .reset_n                          (reset_n),
    .dut_valid                        (dut_valid),
    .dut_ready                        (dut_ready),
    .q_state_input_sram_write_enable  (in_we),
    .q_state_input_sram_write_address (in_waddr),
    .q_state_input_sram_write_data    (in_wdata),
    .q_state_input_sram_read_address  (in_raddr),
    .q_state_input_sram_read_data     (in_rdata),
    .q_state_output_sram_write_enable (out_we),
    .q_state_output_sram_write_address(out_waddr),
    .q_state_output_sram_write_data   (out_wdata),
    .q_state_output_sram_read_data    (out_rdata),
    .scratchpad_sram_write_enable     (scr_we),
    .scratchpad_sram_write_address    (scr_waddr),
    .scratchpad_sram_write_data       (scr_wdata),
    .scratchpad_sram_read_address     (scr_raddr),
    .scratchpad_sram_read_data        (scr_rdata),
    .q_gates_sram_read_address        (gate_raddr),
    .q_gates_sram_read_data           (gate_rdata)
  );

  bind qsim_top qsim_chk qsim_chk_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .dut_ready (dut_ready),
    .input_we  (q_state_input_sram_write_enable),
    .scratch_we(scratchpad_sram_write_enable),
    .output_we (q_state_output_sram_write_enable)
  );

  qsim_monitor qsim_monitor_i (
    .clk           (clk),
    .dut_valid     (dut_valid),
    .dut_ready     (dut_ready),
    .out_we        (out_we),
    .out_addr      (out_waddr),
    .out_data      (out_wdata),
    .in_we         (in_we),
    .in_addr       (in_waddr),
    .in_data       (in_wdata),
    .scr_we        (scr_we),
    .scr_addr      (scr_waddr),
    .scr_data      (scr_wdata),
    .num_rows      (num_rows),
    .input_expected(input_expected),
    .exp_out       (exp_out),
    .exp_in        (exp_in),
    .exp_scr       (exp_scr),
    .mismatch_count(mismatch_count),
    .other_count   (other_count),
    .jobs_checked  (jobs_checked)
  );

  // --------------------------------------------------
  // memory models with one cycle of read latency
  // --------------------------------------------------
  assign out_rdata = '0;

  always @(posedge clk) begin
    gate_rdata <= gate_mem[gate_raddr];
    in_rdata   <= in_mem[in_raddr];
    scr_rdata  <= scr_mem[scr_raddr];
    if (load_input) begin
      for (int i = 0; i <= ROWS; i++) begin
        in_mem[i] = state_init[i];
      end
    end else if (in_we) begin
      in_mem[in_waddr] = in_wdata;
    end
    if (scr_we) begin
      scr_mem[scr_waddr] = scr_wdata;
    end
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // --------------------------------------------------
  // reference model of the fixed-point gate chain
  // --------------------------------------------------
  function automatic word_t complex_mul(input word_t g, input word_t v);
    logic signed [31:0] rr;
    logic signed [31:0] ii;
    logic signed [31:0] ri;
    logic signed [31:0] ir;
    logic [PW-1:0]      re;
    logic [PW-1:0]      im;
    rr = $signed(g[W-1 -: PW]) * $signed(v[W-1 -: PW]);
    ii = $signed(g[PW-1:0]) * $signed(v[PW-1:0]);
    ri = $signed(g[W-1 -: PW]) * $signed(v[PW-1:0]);
    ir = $signed(g[PW-1:0]) * $signed(v[W-1 -: PW]);
    re = PW'(rr >>> `QSIM_FRAC_BITS) - PW'(ii >>> `QSIM_FRAC_BITS);
    im = PW'(ri >>> `QSIM_FRAC_BITS) + PW'(ir >>> `QSIM_FRAC_BITS);
    return {re, im};
  endfunction

  function automatic void ref_apply_gates(input int q, input int m);
    word_t vec [ROWS];
    word_t nxt [ROWS];
    word_t prod;
    int    n;
    n       = 1 << q;
    exp_out = '0;
    exp_in  = '0;
    exp_scr = '0;
    for (int c = 0; c < n; c++) begin
      vec[c] = state_init[c+1];
    end
    for (int g = 0; g < m; g++) begin
      for (int r = 0; r < n; r++) begin
        nxt[r] = '0;
        for (int c = 0; c < n; c++) begin
          prod              = complex_mul(gate_mem[g*n*n + r*n + c], vec[c]);
          nxt[r][W-1 -: PW] = nxt[r][W-1 -: PW] + prod[W-1 -: PW];
          nxt[r][PW-1:0]    = nxt[r][PW-1:0] + prod[PW-1:0];
        end
      end
      // even gates land in the scratchpad, odd ones in the input memory
      for (int r = 0; r < n; r++) begin
        vec[r] = nxt[r];
        if (g % 2 == 0) begin
          exp_scr[r*W +: W] = nxt[r];
        end else begin
          exp_in[r*W +: W] = nxt[r];
        end
      end
    end
    for (int r = 0; r < n; r++) begin
      exp_out[r*W +: W] = vec[r];
    end
  endfunction

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic prepare_job(input int q, input int m, input bit identity);
    int    n;
    int    k;
    word_t one;
    n   = 1 << q;
    one = word_t'(1) << (PW + `QSIM_FRAC_BITS);
    state_init[0] = {16'(q), 16'(m)};
    for (int i = 1; i <= n; i++) begin
      state_init[i] = random_bits(W);
    end
    for (int i = 0; i < m*n*n; i++) begin
      k = i % (n*n);
      if (identity) begin
        gate_mem[i] = (k / n == k % n) ? one : '0;
      end else begin
        gate_mem[i] = random_bits(W);
      end
    end
    ref_apply_gates(q, m);
    num_rows       = (`QSIM_MAX_QUBITS+1)'(n);
    input_expected = (m > 1);
  endtask

  // optional dut_valid pulses while busy, which the DUT must ignore
  task automatic wait_ready(input bit busy_pulses);
    int cycles;
    cycles = 0;
    while (dut_ready !== 1'b1 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      dut_valid = busy_pulses && (cycles % 7 == 0) && !dut_ready;
    end
    dut_valid = 1'b0;
    if (dut_ready !== 1'b1) begin
      timeouts++;
      $display("timed out after %0d cycles waiting for dut_ready", cycles);
    end
  endtask

  task automatic run_job(input int q, input int m, input bit identity, input bit busy_pulses);
    prepare_job(q, m, identity);
    load_input = 1'b1;
    dut_valid  = 1'b1;
    @(negedge clk);
    load_input = 1'b0;
    dut_valid  = 1'b0;
    if (dut_ready !== 1'b0) begin
      tb_errors++;
      $display("dut_ready did not fall after dut_valid was accepted");
    end
    wait_ready(busy_pulses);
    jobs_run++;
  endtask

  initial begin
    lfsr           = 32'h19b4;
    reset_n        = 1'b0;
    dut_valid      = 1'b0;
    load_input     = 1'b0;
    num_rows       = '0;
    input_expected = 1'b0;
    exp_out        = '0;
    exp_in         = '0;
    exp_scr        = '0;
    tb_errors      = 0;
    timeouts       = 0;
    jobs_run       = 0;
    repeat (16) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    if (dut_ready !== 1'b1 || in_we !== 1'b0 || scr_we !== 1'b0 || out_we !== 1'b0) begin
      tb_errors++;
      $display("after reset dut_ready is not high or a write enable is active");
    end
    run_job(1, 1, 1'b1, 1'b0);
    run_job(2, 3, 1'b0, 1'b0);
    run_job(4, 2, 1'b0, 1'b1);
    run_job(4, 2, 1'b0, 1'b0);
    // monitor compares the last job at the next rising edge
    @(negedge clk);
    if (jobs_checked != jobs_run) begin
      tb_errors++;
      $display("monitor compared %0d jobs but %0d were run", jobs_checked, jobs_run);
    end
    assert_fails = qsim_top_i.qsim_chk_i.assert_fails;
    $display("error counts: mismatch %0d, other %0d, testbench %0d, timeout %0d, assertion %0d",
             mismatch_count, other_count, tb_errors, timeouts, assert_fails);
    if (mismatch_count + other_count + tb_errors + timeouts + assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
